//--- flist.f
logic/exu_cfg_pkg.sv
logic/exu_op_pkg.sv
logic/exu_operand_sel.sv
logic/exu_alu.sv
logic/exu_flush_ctl.sv
logic/exu_top.sv
dv/exu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f flist.f \
   --top-module exu_tb \
   -o exu_sim

./obj_dir/exu_sim

//--- dv/exu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for the execute stage
// Clock, reset, stimulus rows, random ALU rows and timeout
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module exu_tb import exu_cfg_pkg::*, exu_op_pkg::*; ();

   localparam int NROWS = 32;
   localparam int NRAND = 40;
   localparam int LIMIT = (NROWS + NRAND) * 4 + 8 + 20;
   localparam int S_GPR = 0, S_R = 1, S_M = 2, S_X = 3, S_NB = 4, S_PC = 5, S_IMM = 6;
   localparam pc_t   PC_ROW = 31'h100;
   localparam pc_t   PATH_R = 31'h2000;      // Lower flush redirect
   localparam pc_t   NPC_X  = 31'h3000;      // Predicted-correct NPC
   localparam data_t JUNK   = 32'hbad0bad0;  // Value on unselected sources

   typedef struct {
      alu_op_e  op;
      br_cond_e cond;
      int       asrc;
      data_t    a;
      int       bsrc;
      data_t    b;
      brimm_t   brimm;
      logic     pred;
      logic     fl;
      logic     xen;
      data_t    res;
      logic     flush;
      pc_t      xpath;
      logic     pcor;
   } row_t;

   logic     clk = 1'b0;
   logic     i_rst;
   data_t    i_gpr_rs1, i_gpr_rs2, i_immed, i_result_r, i_lsu_result_m, i_nbload_data;
   logic     i_rs1_en, i_rs2_en, i_select_pc, i_valid_d, i_pred_taken_d, i_qual_lsu;
   pc_t      i_pc_d, i_flush_path_r, i_pred_correct_npc_x;
   byp_en_t  i_rs1_byp_en, i_rs2_byp_en;
   alu_op_e  i_op;
   br_cond_e i_br_cond;
   brimm_t   i_brimm;
   logic     i_x_data_en, i_r_data_en, i_x_ctl_en, i_r_ctl_en, i_flush_lower_r;
   data_t    o_result_x, o_lsu_rs1, o_lsu_rs2;
   pc_t      o_pc_x, o_flush_path_final, o_npc_r;
   logic     o_flush_final;

   row_t     rows[NROWS];
   int       nfill = 0;
   int       cycles = 0;

   exu_top UUT (.*);

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Run did not finish within %0d cycles", LIMIT);
         $display("TEST RESULT: FAIL");
         $fatal(1);
      end
   end

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1);
      end
   endtask

   task automatic put(input alu_op_e op, input br_cond_e cond, input int asrc,
                      input data_t a, input int bsrc, input data_t b, input brimm_t brimm,
                      input int pred, input int fl, input int xen, input data_t res,
                      input int flush, input pc_t xpath, input int pcor);
      rows[nfill] = '{op, cond, asrc, a, bsrc, b, brimm, (pred != 0), (fl != 0),
                      (xen != 0), res, (flush != 0), xpath, (pcor != 0)};
      nfill++;
   endtask

   // Reference ALU from the opcode definitions
   function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_OR:   return a | b;
         ALU_XOR:  return a ^ b;
         ALU_SLL:  return a << b[4:0];
         ALU_SRL:  return a >> b[4:0];
         ALU_SRA:  return data_t'($signed(a) >>> b[4:0]);
         ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU: return {31'b0, a < b};
         default:  return b;                    // Pass B
      endcase
   endfunction

   // Drives one row in D and checks it in X and then in R
   task automatic apply(input row_t r);
      i_gpr_rs1 = ~r.a;
      i_gpr_rs2 = ~r.b;
      i_rs1_en = 1'b1;
      i_rs2_en = 1'b1;
      i_rs1_byp_en = '0;
      i_rs2_byp_en = '0;
      i_result_r = JUNK;
      i_lsu_result_m = JUNK;
      i_nbload_data = JUNK;
      i_immed = JUNK;
      i_select_pc = 1'b0;
      case (r.asrc)
         S_GPR: i_gpr_rs1 = r.a;
         S_R: begin
            i_rs1_byp_en[BYP_RESULT_R] = 1'b1;
            i_result_r = r.a;
         end
         S_M: begin
            i_rs1_byp_en[BYP_LSU_M] = 1'b1;
            i_lsu_result_m = r.a;
         end
         S_X:   i_rs1_byp_en[BYP_RESULT_X] = 1'b1;
         S_NB: begin
            i_rs1_byp_en[BYP_NBLOAD] = 1'b1;
            i_nbload_data = r.a;
         end
         default: i_select_pc = 1'b1;
      endcase
      case (r.bsrc)
         S_GPR: i_gpr_rs2 = r.b;
         S_R: begin
            i_rs2_byp_en[BYP_RESULT_R] = 1'b1;
            i_result_r = r.b;
         end
         S_M: begin
            i_rs2_byp_en[BYP_LSU_M] = 1'b1;
            i_lsu_result_m = r.b;
         end
         S_X:   i_rs2_byp_en[BYP_RESULT_X] = 1'b1;
         S_NB: begin
            i_rs2_byp_en[BYP_NBLOAD] = 1'b1;
            i_nbload_data = r.b;
         end
         default: begin
            i_rs2_en = 1'b0;
            i_immed = r.b;
         end
      endcase
      i_op = r.op;
      i_br_cond = r.cond;
      i_brimm = r.brimm;
      i_pc_d = PC_ROW;
      i_valid_d = 1'b1;
      i_pred_taken_d = r.pred;
      i_x_data_en = r.xen;
      i_x_ctl_en = r.xen;
      i_flush_lower_r = 1'b0;
      #1;
      check(o_lsu_rs1, '0, "lsu rs1 without qual");
      check(o_lsu_rs2, '0, "lsu rs2 without qual");
      @(negedge clk);
      i_x_data_en = 1'b0;                          // Hold X for the next row
      i_x_ctl_en = 1'b0;
      i_valid_d = 1'b0;
      i_pc_d = ~PC_ROW;                            // X keeps its own PC
      i_flush_lower_r = r.fl;
      #1;
      check(o_result_x, r.res, "result_x");
      check({1'b0, o_pc_x}, {1'b0, PC_ROW}, "pc_x");
      check({31'b0, o_flush_final}, {31'b0, r.flush | r.fl}, "flush_final");
      if (r.flush | r.fl)
         check({1'b0, o_flush_path_final}, {1'b0, r.fl ? PATH_R : r.xpath}, "flush path");
      @(posedge clk);
      #1;
      check({1'b0, o_npc_r}, {1'b0, r.pcor ? NPC_X : r.xpath}, "npc_r");
      @(negedge clk);
   endtask

   task automatic fill_table();
      put(ALU_ADD, BR_NONE, S_GPR, 'h7fffffff, S_GPR, 'h1, 'h0, 0, 0, 1, 'h80000000, 0, 'h102, 0);
      put(ALU_SUB, BR_NONE, S_GPR, 'h0, S_GPR, 'h1, 'h0, 0, 0, 1, 'hffffffff, 0, 'h102, 0);
      put(ALU_AND, BR_NONE, S_GPR, 'hf0f0f0f0, S_IMM, 'h0ff00ff0, 'h0, 0, 0, 1, 'h00f000f0, 0, 'h102, 0);
      put(ALU_OR, BR_NONE, S_GPR, 'hf0f0f0f0, S_IMM, 'h0f0f0000, 'h0, 0, 0, 1, 'hfffff0f0, 0, 'h102, 0);
      put(ALU_XOR, BR_NONE, S_GPR, 'hffff0000, S_GPR, 'hff00ff00, 'h0, 0, 0, 1, 'h00ffff00, 0, 'h102, 0);
      put(ALU_SLL, BR_NONE, S_GPR, 'h1, S_IMM, 'h1f, 'h0, 0, 0, 1, 'h80000000, 0, 'h102, 0);
      put(ALU_SRL, BR_NONE, S_GPR, 'h80000000, S_GPR, 'h24, 'h0, 0, 0, 1, 'h08000000, 0, 'h102, 0);
      put(ALU_SRA, BR_NONE, S_GPR, 'h80000000, S_GPR, 'h4, 'h0, 0, 0, 1, 'hf8000000, 0, 'h102, 0);
      put(ALU_SLT, BR_NONE, S_GPR, 'hffffffff, S_GPR, 'h1, 'h0, 0, 0, 1, 'h1, 0, 'h102, 0);
      put(ALU_SLTU, BR_NONE, S_GPR, 'hffffffff, S_GPR, 'h1, 'h0, 0, 0, 1, 'h0, 0, 'h102, 0);
      put(ALU_PASSB, BR_NONE, S_GPR, 'hdead, S_IMM, 'hcafebabe, 'h0, 0, 0, 1, 'hcafebabe, 0, 'h102, 0);
      // Bypass sources, X result taken from the row before
      put(ALU_ADD, BR_NONE, S_R, 'h10, S_GPR, 'h5, 'h0, 0, 0, 1, 'h15, 0, 'h102, 0);
      put(ALU_ADD, BR_NONE, S_GPR, 'h1, S_M, 'h20, 'h0, 0, 0, 1, 'h21, 0, 'h102, 0);
      put(ALU_ADD, BR_NONE, S_X, 'h0, S_NB, 'h100, 'h0, 0, 0, 1, 'h121, 0, 'h102, 0);
      put(ALU_SUB, BR_NONE, S_NB, 'h50, S_X, 'h0, 'h0, 0, 0, 1, 'hffffff2f, 0, 'h102, 0);
      put(ALU_ADD, BR_NONE, S_GPR, 'h1, S_GPR, 'h1, 'h0, 0, 0, 0, 'hffffff2f, 0, 'h102, 0);
      // Branches, taken path 0x110 and fall-through 0x102
      put(ALU_ADD, BR_EQ, S_GPR, 'h5, S_GPR, 'h5, 'h010, 0, 0, 1, 'h0, 1, 'h110, 0);
      put(ALU_ADD, BR_EQ, S_GPR, 'h5, S_GPR, 'h5, 'h010, 1, 0, 1, 'h0, 0, 'h110, 1);
      put(ALU_ADD, BR_NE, S_GPR, 'h5, S_GPR, 'h5, 'h010, 1, 0, 1, 'h0, 1, 'h102, 0);
      put(ALU_ADD, BR_NE, S_GPR, 'h5, S_GPR, 'h6, 'h010, 0, 0, 1, 'h0, 1, 'h110, 0);
      put(ALU_ADD, BR_LT, S_GPR, 'hffffffff, S_GPR, 'h1, 'h010, 0, 0, 1, 'h0, 1, 'h110, 0);
      put(ALU_ADD, BR_LT, S_GPR, 'h1, S_GPR, 'hffffffff, 'h010, 1, 0, 1, 'h0, 1, 'h102, 0);
      put(ALU_ADD, BR_GE, S_GPR, 'h1, S_GPR, 'hffffffff, 'h010, 0, 0, 1, 'h0, 1, 'h110, 0);
      put(ALU_ADD, BR_GE, S_GPR, 'hffffffff, S_GPR, 'h1, 'h010, 1, 0, 1, 'h0, 1, 'h102, 0);
      put(ALU_ADD, BR_LTU, S_GPR, 'h1, S_GPR, 'hffffffff, 'h010, 1, 0, 1, 'h0, 0, 'h110, 1);
      put(ALU_ADD, BR_LTU, S_GPR, 'hffffffff, S_GPR, 'h1, 'h010, 0, 0, 1, 'h0, 0, 'h102, 1);
      put(ALU_ADD, BR_GEU, S_GPR, 'hffffffff, S_GPR, 'h1, 'h010, 0, 0, 1, 'h0, 1, 'h110, 0);
      put(ALU_ADD, BR_GEU, S_GPR, 'h1, S_GPR, 'hffffffff, 'h010, 1, 0, 1, 'h0, 1, 'h102, 0);
      // Jal links PC plus 4, backward target 0xf8
      put(ALU_ADD, BR_JAL, S_PC, 'h0, S_IMM, 'h0, 'hff8, 1, 0, 1, 'h204, 0, 'hf8, 1);
      put(ALU_ADD, BR_JAL, S_PC, 'h0, S_IMM, 'h0, 'hff8, 0, 0, 1, 'h204, 1, 'hf8, 0);
      // PC byte address plus an immediate
      put(ALU_ADD, BR_NONE, S_PC, 'h0, S_IMM, 'h10, 'h0, 0, 0, 1, 'h210, 0, 'h102, 0);
      // Lower flush over an X mispredict
      put(ALU_ADD, BR_EQ, S_GPR, 'h5, S_GPR, 'h6, 'h010, 1, 1, 1, 'h0, 1, 'h102, 0);
   endtask

   initial begin
      row_t  rr;
      data_t rnd;
      void'($urandom(47));
      i_rst = 1'b1;
      i_gpr_rs1 = '0;
      i_gpr_rs2 = '0;
      i_immed = '0;
      i_result_r = '0;
      i_lsu_result_m = '0;
      i_nbload_data = '0;
      i_rs1_en = 1'b0;
      i_rs2_en = 1'b0;
      i_select_pc = 1'b0;
      i_valid_d = 1'b0;
      i_pred_taken_d = 1'b0;
      i_qual_lsu = 1'b0;
      i_pc_d = '0;
      i_flush_path_r = PATH_R;
      i_pred_correct_npc_x = NPC_X;
      i_rs1_byp_en = '0;
      i_rs2_byp_en = '0;
      i_op = ALU_ADD;
      i_br_cond = BR_NONE;
      i_brimm = '0;
      i_x_data_en = 1'b1;
      i_x_ctl_en = 1'b1;
      i_r_data_en = 1'b1;
      i_r_ctl_en = 1'b1;
      i_flush_lower_r = 1'b0;
      fill_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      i_gpr_rs1 = 32'h11;
      i_gpr_rs2 = 32'h22;
      i_rs1_en = 1'b1;
      i_rs2_en = 1'b1;
      i_qual_lsu = 1'b1;
      #1;
      check({31'b0, o_flush_final}, '0, "flush_final after reset");
      check(o_lsu_rs1, 32'h11, "lsu rs1 with qual");
      check(o_lsu_rs2, 32'h22, "lsu rs2 with qual");
      @(negedge clk);
      i_qual_lsu = 1'b0;
      for (int i = 0; i < NROWS; i++)
         apply(rows[i]);
      for (int i = 0; i < NRAND; i++) begin
         rnd = $urandom_range(10, 0);
         rr = rows[0];
         rr.op = alu_op_e'(rnd[3:0]);
         rr.a = $urandom();
         rr.b = $urandom();
         rr.res = alu_model(rr.op, rr.a, rr.b);
         apply(rr);
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/exu_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Integer execute stage top
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_cfg_pkg::*, exu_op_pkg::*; (
   input  logic     clk,
   input  logic     i_rst,
   input  data_t    i_gpr_rs1,             // D-stage operand sources
   input  data_t    i_gpr_rs2,
   input  logic     i_rs1_en,
   input  logic     i_rs2_en,
   input  data_t    i_immed,
   input  pc_t      i_pc_d,
   input  logic     i_select_pc,
   input  byp_en_t  i_rs1_byp_en,
   input  byp_en_t  i_rs2_byp_en,
   input  data_t    i_result_r,
   input  data_t    i_lsu_result_m,
   input  data_t    i_nbload_data,
   input  logic     i_valid_d,             // Decode
   input  alu_op_e  i_op,
   input  br_cond_e i_br_cond,
   input  brimm_t   i_brimm,
   input  logic     i_pred_taken_d,
   input  logic     i_qual_lsu,
   input  logic     i_x_data_en,           // Stage enables
   input  logic     i_r_data_en,
   input  logic     i_x_ctl_en,
   input  logic     i_r_ctl_en,
   input  logic     i_flush_lower_r,       // R-stage controls
   input  pc_t      i_flush_path_r,
   input  pc_t      i_pred_correct_npc_x,
   output data_t    o_result_x,
   output pc_t      o_pc_x,
   output data_t    o_lsu_rs1,
   output data_t    o_lsu_rs2,
   output logic     o_flush_final,
   output pc_t      o_flush_path_final,
   output pc_t      o_npc_r
);

   data_t rs1_d;
   data_t rs2_d;
   logic  flush_upper_x;
   pc_t   flush_path_x;
   logic  pred_correct_x;

   exu_operand_sel u_operand_sel (
      .i_gpr_rs1      (i_gpr_rs1),
      .i_gpr_rs2      (i_gpr_rs2),
      .i_rs1_en       (i_rs1_en),
      .i_rs2_en       (i_rs2_en),
      .i_select_pc    (i_select_pc),
      .i_qual_lsu     (i_qual_lsu),
      .i_pc_d         (i_pc_d),
      .i_immed        (i_immed),
      .i_rs1_byp_en   (i_rs1_byp_en),
      .i_rs2_byp_en   (i_rs2_byp_en),
      .i_result_r     (i_result_r),
      .i_lsu_result_m (i_lsu_result_m),
      .i_result_x     (o_result_x),        // X result fed back as bypass
      .i_nbload_data  (i_nbload_data),
      .o_rs1          (rs1_d),
      .o_rs2          (rs2_d),
      .o_lsu_rs1      (o_lsu_rs1),
      .o_lsu_rs2      (o_lsu_rs2)
   );

   exu_alu u_alu (
      .clk              (clk),
      .i_rst            (i_rst),
      .i_x_data_en      (i_x_data_en),
      .i_x_ctl_en       (i_x_ctl_en),
      .i_valid_d        (i_valid_d),
      .i_op             (i_op),
      .i_br_cond        (i_br_cond),
      .i_a              (rs1_d),
      .i_b              (rs2_d),
      .i_pc_d           (i_pc_d),
      .i_brimm          (i_brimm),
      .i_pred_taken_d   (i_pred_taken_d),
      .i_flush_lower_r  (i_flush_lower_r),
      .o_result_x       (o_result_x),
      .o_pc_x           (o_pc_x),
      .o_flush_upper_x  (flush_upper_x),
      .o_flush_path_x   (flush_path_x),
      .o_pred_correct_x (pred_correct_x)
   );

   exu_flush_ctl u_flush_ctl (
      .clk                  (clk),
      .i_rst                (i_rst),
      .i_r_data_en          (i_r_data_en),
      .i_r_ctl_en           (i_r_ctl_en),
      .i_flush_lower_r      (i_flush_lower_r),
      .i_flush_path_r       (i_flush_path_r),
      .i_flush_upper_x      (flush_upper_x),
      .i_flush_path_x       (flush_path_x),
      .i_pred_correct_x     (pred_correct_x),
      .i_pred_correct_npc_x (i_pred_correct_npc_x),
      .o_flush_final        (o_flush_final),
      .o_flush_path_final   (o_flush_path_final),
      .o_npc_r              (o_npc_r)
   );

endmodule

`default_nettype wire

//--- logic/exu_flush_ctl.sv
// ~~~~~~~~~~~~~~~~~~~~
// Final flush select and R-stage next PC
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module exu_flush_ctl import exu_cfg_pkg::*; (
   input  logic clk,
   input  logic i_rst,
   input  logic i_r_data_en,           // Capture paths into R
   input  logic i_r_ctl_en,            // Capture pred-correct into R
   input  logic i_flush_lower_r,       // Older flush from R
   input  pc_t  i_flush_path_r,
   input  logic i_flush_upper_x,       // Mispredict in X
   input  pc_t  i_flush_path_x,
   input  logic i_pred_correct_x,
   input  pc_t  i_pred_correct_npc_x,
   output logic o_flush_final,
   output pc_t  o_flush_path_final,
   output pc_t  o_npc_r
);

   pc_t  flush_path_upper_r;
   pc_t  pred_correct_npc_r;
   logic pred_correct_upper_r;

   assign o_flush_final      = i_flush_lower_r | i_flush_upper_x;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r : i_flush_path_x;  // Oldest wins

   always_ff @(posedge clk) begin
      if (i_r_data_en) begin
         flush_path_upper_r <= i_flush_path_x;
         pred_correct_npc_r <= i_pred_correct_npc_x;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst)
         pred_correct_upper_r <= 1'b0;
      else if (i_r_ctl_en)
         pred_correct_upper_r <= i_pred_correct_x;
   end

   assign o_npc_r = pred_correct_upper_r ? pred_correct_npc_r : flush_path_upper_r;

   // Only the X stage may flush on its own
   assert property (@(posedge clk) disable iff (i_rst)
                    (o_flush_final && !i_flush_lower_r) |-> i_flush_upper_x)
      else $error("final flush without a source");

endmodule

`default_nettype wire

//--- logic/exu_alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// X-stage registers, ALU, branch compare and mispredict detect
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_cfg_pkg::*, exu_op_pkg::*; (
   input  logic     clk,
   input  logic     i_rst,
   input  logic     i_x_data_en,       // Capture operands into X
   input  logic     i_x_ctl_en,        // Capture valid and prediction into X
   input  logic     i_valid_d,         // ALU instruction valid in D
   input  alu_op_e  i_op,
   input  br_cond_e i_br_cond,
   input  data_t    i_a,
   input  data_t    i_b,
   input  pc_t      i_pc_d,
   input  brimm_t   i_brimm,
   input  logic     i_pred_taken_d,
   input  logic     i_flush_lower_r,   // Kills the D instruction
   output data_t    o_result_x,
   output pc_t      o_pc_x,
   output logic     o_flush_upper_x,   // X branch mispredicted
   output pc_t      o_flush_path_x,
   output logic     o_pred_correct_x
);

   data_t    a_x;
   data_t    b_x;
   pc_t      pc_x;
   brimm_t   brimm_x;
   alu_op_e  op_x;
   br_cond_e cond_x;
   logic     valid_x;
   logic     pred_taken_x;

   data_t    alu_res;
   logic     eq_x;
   logic     lt_x;
   logic     ltu_x;
   logic     taken_x;
   logic     is_br_x;
   pc_t      pc_next_x;
   pc_t      pc_target_x;

   // Operand and decode payload
   always_ff @(posedge clk) begin
      if (i_x_data_en) begin
         a_x     <= i_a;
         b_x     <= i_b;
         pc_x    <= i_pc_d;
         brimm_x <= i_brimm;
         op_x    <= i_op;
         cond_x  <= i_br_cond;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid_x      <= 1'b0;
         pred_taken_x <= 1'b0;
      end else if (i_x_ctl_en) begin
         valid_x      <= i_valid_d & ~i_flush_lower_r;
         pred_taken_x <= i_pred_taken_d;
      end
   end

   assign eq_x  = (a_x == b_x);
   assign lt_x  = ($signed(a_x) < $signed(b_x));
   assign ltu_x = (a_x < b_x);

   always_comb begin
      unique case (op_x)
         ALU_ADD:   alu_res = a_x + b_x;
         ALU_SUB:   alu_res = a_x - b_x;
         ALU_AND:   alu_res = a_x & b_x;
         ALU_OR:    alu_res = a_x | b_x;
         ALU_XOR:   alu_res = a_x ^ b_x;
         ALU_SLL:   alu_res = a_x << b_x[4:0];
         ALU_SRL:   alu_res = a_x >> b_x[4:0];
         ALU_SRA:   alu_res = data_t'($signed(a_x) >>> b_x[4:0]);
         ALU_SLT:   alu_res = data_t'(lt_x);
         ALU_SLTU:  alu_res = data_t'(ltu_x);
         ALU_PASSB: alu_res = b_x;
         default:   alu_res = '0;                 // Unused encodings
      endcase
   end

   always_comb begin
      unique case (cond_x)
         BR_EQ:   taken_x = eq_x;
         BR_NE:   taken_x = ~eq_x;
         BR_LT:   taken_x = lt_x;
         BR_GE:   taken_x = ~lt_x;
         BR_LTU:  taken_x = ltu_x;
         BR_GEU:  taken_x = ~ltu_x;
         BR_JAL:  taken_x = 1'b1;
         default: taken_x = 1'b0;                 // BR_NONE
      endcase
   end

   assign is_br_x     = (cond_x != BR_NONE);
   assign pc_next_x   = pc_x + PC_W'(2);           // PC plus 4 in halfwords
   assign pc_target_x = pc_x + {{(PC_W-BRIMM_W){brimm_x[BRIMM_W-1]}}, brimm_x};

   // Link value for jal, branches write nothing
   always_comb begin
      if (cond_x == BR_JAL)
         o_result_x = {pc_next_x, 1'b0};
      else if (is_br_x)
         o_result_x = '0;
      else
         o_result_x = alu_res;
   end

   assign o_pc_x           = pc_x;
   assign o_flush_path_x   = taken_x ? pc_target_x : pc_next_x;
   assign o_flush_upper_x  = valid_x & is_br_x & (taken_x != pred_taken_x);
   assign o_pred_correct_x = valid_x & is_br_x & (taken_x == pred_taken_x);

   assert property (@(posedge clk) disable iff (i_rst)
                    !(o_flush_upper_x && o_pred_correct_x))
      else $error("upper flush and pred-correct both high");

endmodule

`default_nettype wire

//--- logic/exu_operand_sel.sv
// ~~~~~~~~~~~~~~~~~~~~
// D-stage operand select with one-hot bypass merge
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module exu_operand_sel import exu_cfg_pkg::*; (
   input  data_t   i_gpr_rs1,       // GPR read data
   input  data_t   i_gpr_rs2,
   input  logic    i_rs1_en,        // Qualify GPR rs1
   input  logic    i_rs2_en,        // Qualify GPR rs2
   input  logic    i_select_pc,     // PC onto rs1 for jal
   input  logic    i_qual_lsu,      // Load or store in D
   input  pc_t     i_pc_d,
   input  data_t   i_immed,
   input  byp_en_t i_rs1_byp_en,    // One-hot bypass select
   input  byp_en_t i_rs2_byp_en,
   input  data_t   i_result_r,      // Bypass sources
   input  data_t   i_lsu_result_m,
   input  data_t   i_result_x,
   input  data_t   i_nbload_data,
   output data_t   o_rs1,           // ALU operands
   output data_t   o_rs2,
   output data_t   o_lsu_rs1,       // LSU operands
   output data_t   o_lsu_rs2
);

   logic  rs1_byp_any;
   logic  rs2_byp_any;
   data_t rs1_byp_data;
   data_t rs2_byp_data;
   data_t rs1_reg;
   data_t rs2_reg;

   // AND-OR merge of the bypass sources
   function automatic data_t byp_merge(input byp_en_t en, input data_t r_res,
                                       input data_t m_res, input data_t x_res,
                                       input data_t nb_res);
      byp_merge = ({XLEN{en[BYP_RESULT_R]}} & r_res) |
                  ({XLEN{en[BYP_LSU_M]}}    & m_res) |
                  ({XLEN{en[BYP_RESULT_X]}} & x_res) |
                  ({XLEN{en[BYP_NBLOAD]}}   & nb_res);
   endfunction

   assign rs1_byp_any  = |i_rs1_byp_en;
   assign rs2_byp_any  = |i_rs2_byp_en;
   assign rs1_byp_data = byp_merge(i_rs1_byp_en, i_result_r, i_lsu_result_m,
                                   i_result_x, i_nbload_data);
   assign rs2_byp_data = byp_merge(i_rs2_byp_en, i_result_r, i_lsu_result_m,
                                   i_result_x, i_nbload_data);

   // Register value with bypass, no PC or immediate
   assign rs1_reg = rs1_byp_any ? rs1_byp_data : (i_rs1_en ? i_gpr_rs1 : '0);
   assign rs2_reg = rs2_byp_any ? rs2_byp_data : (i_rs2_en ? i_gpr_rs2 : '0);

   always_comb begin
      if (rs1_byp_any)
         o_rs1 = rs1_byp_data;
      else if (i_select_pc)
         o_rs1 = {i_pc_d, 1'b0};                     // Byte address of the jal
      else
         o_rs1 = rs1_reg;
   end

   assign o_rs2 = (rs2_byp_any || i_rs2_en) ? rs2_reg : i_immed;

   assign o_lsu_rs1 = i_qual_lsu ? rs1_reg : '0;     // Quiet unless load or store
   assign o_lsu_rs2 = i_qual_lsu ? rs2_reg : '0;

   // Decode must never select two bypass sources at once
   always_comb begin
      assert ($onehot0(i_rs1_byp_en)) else $error("rs1 bypass enable not one-hot");
      assert ($onehot0(i_rs2_byp_en)) else $error("rs2 bypass enable not one-hot");
   end

endmodule

`default_nettype wire

//--- logic/exu_op_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// ALU opcode and branch condition encodings
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package exu_op_pkg;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
      ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASSB
   } alu_op_e;

   // BR_NONE marks a plain ALU instruction
   typedef enum logic [2:0] {
      BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL
   } br_cond_e;

endpackage

`default_nettype wire

//--- logic/exu_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Execute stage widths, bypass source indices and datapath types
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package exu_cfg_pkg;

   localparam int XLEN    = 32;      // Integer data width
   localparam int PC_W    = 31;      // PC bits 31 to 1
   localparam int BRIMM_W = 12;      // Branch offset bits 12 to 1
   localparam int NUM_BYP = 4;       // Bypass sources per operand

   // One-hot bypass enable bit positions
   localparam int BYP_RESULT_R = 0;  // R-stage result
   localparam int BYP_LSU_M    = 1;  // Load result in M
   localparam int BYP_RESULT_X = 2;  // X-stage ALU result
   localparam int BYP_NBLOAD   = 3;  // Nonblocking load data

   typedef logic [XLEN-1:0]    data_t;
   typedef logic [PC_W-1:0]    pc_t;     // Halfword address
   typedef logic [BRIMM_W-1:0] brimm_t;  // Halfword offset
   typedef logic [NUM_BYP-1:0] byp_en_t;

endpackage

`default_nettype wire
